//--- ooo_stim.txt
// inst dest a_rdy a_tag a_value b_rdy b_tag b_value expected
// one micro-op per line, all fields hex, waiting sources carry value 0
00000000 01 1 00 00000005 1 00 00000007 0000000C
10000000 02 0 01 00000000 1 00 00000002 0000000A
30000000 03 1 00 000000FF 0 01 00000000 000000F3
20000000 04 0 02 00000000 1 00 0000000E 0000000A
00000000 05 0 01 00000000 0 01 00000000 00000018
40000000 06 1 00 00000003 1 00 00000004 00000030
50000000 07 1 00 80000000 1 00 0000001F 00000001
60000000 08 1 00 00012345 1 00 00010000 23450000
F0000000 09 1 00 00000100 1 00 00000023 00000123
10000000 0A 1 00 00000000 1 00 00000001 FFFFFFFF
40000000 0B 1 00 00000001 1 00 00000025 00000020
60000000 0C 1 00 00000007 1 00 00000006 0000002A
40000000 0D 0 0C 00000000 1 00 00000002 000000A8
00000000 0E 0 0D 00000000 1 00 00000001 000000A9
60000000 0F 0 0E 00000000 0 0C 00000000 00001BBA
60000000 10 1 00 00000003 1 00 00000005 0000000F
60000000 11 0 10 00000000 1 00 00000003 0000002D
60000000 12 0 11 00000000 1 00 00000002 0000005A
60000000 13 0 12 00000000 1 00 00000002 000000B4
40000000 14 0 12 00000000 1 00 00000001 000000B4
50000000 15 0 12 00000000 1 00 00000004 00000005
60000000 16 0 12 00000000 0 12 00000000 00001FA4
40000000 17 0 12 00000000 1 00 00000008 00005A00
60000000 18 1 00 00000010 0 12 00000000 000005A0
50000000 19 0 12 00000000 1 00 00000001 0000002D
60000000 1A 0 12 00000000 1 00 00000000 00000000

//--- flist.f
ooo_pkg.sv
inst_decode.sv
prio_select.sv
rs_entry.sv
rs.sv
exec_units.sv
cdb_drive.sv
ooo_issue_top.sv
ooo_issue_sva.sv
tb_ooo_issue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the issue slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_ooo_issue -f flist.f -o sim_ooo
./obj_dir/sim_ooo | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run_sim: testbench passed"
else
	echo "run_sim: testbench failed"
	exit 1
fi

//--- tb_ooo_issue.sv
// ******************************
// Testbench for the issue slice
// File driven dispatch, CDB checker, timeout
// ******************************

`timescale 1ns/1ps

module tb_ooo_issue;
	import ooo_pkg::*;

	localparam int N_OPS       = 26;
	localparam int N_COLS      = 9;
	localparam int RS_ENTRIES  = 8;
	localparam int N_TAGS      = 2 ** TAG_W;
	localparam int TIMEOUT_CYC = 20 * N_OPS + 100;

	logic      clk;
	logic      rst;
	logic      dispatch_vld_i;
	dispatch_t dispatch_i;
	logic      full_o;
	cdb_t      cdb_o;

	logic [31:0]       stim [N_OPS*N_COLS];
	logic [DATA_W-1:0] exp_val [N_TAGS];
	logic              exp_pend [N_TAGS];
	logic              exp_used [N_TAGS];
	int                pend_cnt;
	int                err_cnt;
	int                chk_cnt;
	int                cyc_cnt;
	logic              saw_full;
	logic [31:0]       seed;

	ooo_issue_top #(
		.RS_ENTRIES (RS_ENTRIES),
		.ALU_LAT    (1),
		.SHIFT_LAT  (2),
		.MULT_LAT   (3)
	) dut (
		.clk            (clk),
		.rst            (rst),
		.dispatch_vld_i (dispatch_vld_i),
		.dispatch_i     (dispatch_i),
		.full_o         (full_o),
		.cdb_o          (cdb_o)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at time %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Expected result per destination tag
	task automatic load_expected();
		logic [TAG_W-1:0] dest;
		for (int t = 0; t < N_TAGS; t++) begin
			exp_pend[t] = 1'b0;
			exp_used[t] = 1'b0;
			exp_val[t]  = '0;
		end
		pend_cnt = 0;
		for (int k = 0; k < N_OPS; k++) begin
			dest           = TAG_W'(stim[k*N_COLS+1]);
			exp_val[dest]  = stim[k*N_COLS+8];
			exp_pend[dest] = 1'b1;
			exp_used[dest] = 1'b1;
			pend_cnt++;
		end
	endtask

	task automatic send_uop(input int k);
		int base;
		int gap;
		base = k * N_COLS;
		// Idle gaps only ahead of fully ready micro-ops so waiters never miss a producer
		if (stim[base+2][0] && stim[base+5][0]) begin
			seed = lcg_next(seed);
			gap  = int'(seed[17:16]);
			repeat (gap) @(negedge clk);
		end
		while (full_o) begin
			@(negedge clk);
		end
		dispatch_i.inst        = stim[base];
		dispatch_i.dest        = TAG_W'(stim[base+1]);
		dispatch_i.src_a.rdy   = stim[base+2][0];
		dispatch_i.src_a.tag   = TAG_W'(stim[base+3]);
		dispatch_i.src_a.value = stim[base+4];
		dispatch_i.src_b.rdy   = stim[base+5][0];
		dispatch_i.src_b.tag   = TAG_W'(stim[base+6]);
		dispatch_i.src_b.value = stim[base+7];
		dispatch_vld_i         = 1'b1;
		@(negedge clk);
		dispatch_vld_i = 1'b0;
	endtask

	// ******************************
	// CDB monitor and timeout
	// ******************************
	task automatic watch_cdb();
		forever begin
			@(negedge clk);
			if (!rst && full_o) begin
				saw_full = 1'b1;
			end
			if (!rst && cdb_o.valid === 1'b1) begin
				if (!exp_used[cdb_o.tag]) begin
					err_cnt++;
					$display("Error at time %0t: CDB broadcast of tag %0d that no micro-op owns",
						$time, cdb_o.tag);
				end else if (!exp_pend[cdb_o.tag]) begin
					err_cnt++;
					$display("Error at time %0t: tag %0d broadcast more than once",
						$time, cdb_o.tag);
				end else begin
					exp_pend[cdb_o.tag] = 1'b0;
					pend_cnt--;
					check_value($sformatf("cdb_o.value of tag %0d", cdb_o.tag), cdb_o.value,
						exp_val[cdb_o.tag]);
				end
			end
		end
	endtask

	task automatic watch_timeout();
		cyc_cnt = 0;
		while (cyc_cnt < TIMEOUT_CYC) begin
			@(posedge clk);
			cyc_cnt++;
		end
		err_cnt++;
		$display("Timeout after %0d cycles with %0d results outstanding", cyc_cnt, pend_cnt);
		for (int t = 0; t < N_TAGS; t++) begin
			if (exp_pend[t]) begin
				$display("Tag %0d was never broadcast", t);
			end
		end
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		dispatch_vld_i = 1'b0;
		dispatch_i     = '0;
		err_cnt        = 0;
		chk_cnt        = 0;
		saw_full       = 1'b0;
		seed           = 32'h2810_3028;
		$readmemh("ooo_stim.txt", stim);
		load_expected();
		fork
			watch_cdb();
			watch_timeout();
		join_none

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("cdb_o.valid", 32'(cdb_o.valid), 32'd0);
		check_value("full_o", 32'(full_o), 32'd0);

		if ($isunknown(stim[N_OPS*N_COLS-1])) begin
			err_cnt++;
			$display("Stimulus file ooo_stim.txt is missing or holds fewer than %0d micro-ops",
				N_OPS);
		end else begin
			for (int k = 0; k < N_OPS; k++) begin
				send_uop(k);
			end
			while (pend_cnt > 0) begin
				@(negedge clk);
			end
			// Quiet window for late duplicates
			repeat (10) @(negedge clk);
			check_value("full_o", 32'(full_o), 32'd0);
			if (!saw_full) begin
				err_cnt++;
				$display("full_o never rose while the RS held waiting micro-ops");
			end
		end

		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- ooo_issue_sva.sv
// ******************************
// CDB, full flag and reset assertions
// ******************************

`timescale 1ns/1ps

module ooo_issue_sva (
	input logic          clk,
	input logic          rst,
	input logic          dispatch_vld_i,
	input logic          full_i,
	input ooo_pkg::cdb_t alu_i,
	input ooo_pkg::cdb_t shift_i,
	input ooo_pkg::cdb_t mult_i,
	input ooo_pkg::cdb_t cdb_i
);

	// One unit completion per cycle keeps the CDB unique
	a_one_done: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_i.valid, shift_i.valid, mult_i.valid}))
		else $error("More than one unit completed in the same cycle");

	a_no_disp_full: assert property (@(posedge clk) disable iff (rst)
		!(dispatch_vld_i && full_i))
		else $error("Dispatch strobe while the RS is full");

	// Clean state right after a reset cycle
	a_rst_clear: assert property (@(posedge clk) rst |=> (!cdb_i.valid && !full_i))
		else $error("CDB valid or full flag set after reset");

endmodule

bind ooo_issue_top ooo_issue_sva u_sva (
	.clk            (clk),
	.rst            (rst),
	.dispatch_vld_i (dispatch_vld_i),
	.full_i         (full_o),
	.alu_i          (alu_res),
	.shift_i        (shift_res),
	.mult_i         (mult_res),
	.cdb_i          (cdb_o)
);

//--- ooo_issue_top.sv
// ******************************
// Issue and completion slice top
// ******************************

`timescale 1ns/1ps

module ooo_issue_top #(
	parameter int RS_ENTRIES = 8,
	parameter int ALU_LAT    = 1,
	parameter int SHIFT_LAT  = 2,
	parameter int MULT_LAT   = 3
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               dispatch_vld_i,
	input  ooo_pkg::dispatch_t dispatch_i,
	output logic               full_o,
	output ooo_pkg::cdb_t      cdb_o
);
	import ooo_pkg::*;

	uop_t   dec_uop;
	issue_t iss;
	cdb_t   alu_res;
	cdb_t   shift_res;
	cdb_t   mult_res;

	inst_decode u_dec (
		.dispatch_i (dispatch_i),
		.uop_o      (dec_uop)
	);

	// CDB loops back for wakeup
	rs #(
		.RS_ENTRIES (RS_ENTRIES),
		.ALU_LAT    (ALU_LAT),
		.SHIFT_LAT  (SHIFT_LAT),
		.MULT_LAT   (MULT_LAT)
	) u_rs (
		.clk            (clk),
		.rst            (rst),
		.dispatch_vld_i (dispatch_vld_i),
		.uop_i          (dec_uop),
		.cdb_i          (cdb_o),
		.full_o         (full_o),
		.issue_o        (iss)
	);

	exec_units #(
		.ALU_LAT   (ALU_LAT),
		.SHIFT_LAT (SHIFT_LAT),
		.MULT_LAT  (MULT_LAT)
	) u_exec (
		.clk     (clk),
		.rst     (rst),
		.issue_i (iss),
		.alu_o   (alu_res),
		.shift_o (shift_res),
		.mult_o  (mult_res)
	);

	cdb_drive u_cdb (
		.clk     (clk),
		.rst     (rst),
		.alu_i   (alu_res),
		.shift_i (shift_res),
		.mult_i  (mult_res),
		.cdb_o   (cdb_o)
	);

endmodule

//--- cdb_drive.sv
// ******************************
// CDB result register
// ******************************

`timescale 1ns/1ps

module cdb_drive (
	input  logic          clk,
	input  logic          rst,
	input  ooo_pkg::cdb_t alu_i,
	input  ooo_pkg::cdb_t shift_i,
	input  ooo_pkg::cdb_t mult_i,
	output ooo_pkg::cdb_t cdb_o
);
	import ooo_pkg::*;

	cdb_t              pick;
	logic              any_vld;
	logic              vld_q;
	logic [TAG_W-1:0]  tag_q;
	logic [DATA_W-1:0] val_q;

	// At most one lane is valid thanks to the issue schedule
	always_comb begin
		pick = mult_i;
		if (shift_i.valid) begin
			pick = shift_i;
		end
		if (alu_i.valid) begin
			pick = alu_i;
		end
	end

	assign any_vld = alu_i.valid | shift_i.valid | mult_i.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= any_vld;
		end
	end

	always_ff @(posedge clk) begin
		tag_q <= pick.tag;
		val_q <= pick.value;
	end

	assign cdb_o = '{valid: vld_q, tag: tag_q, value: val_q};

endmodule

//--- exec_units.sv
// ******************************
// ALU, shifter and multiplier pipelines
// ******************************

`timescale 1ns/1ps

module exec_units #(
	parameter int ALU_LAT   = 1,
	parameter int SHIFT_LAT = 2,
	parameter int MULT_LAT  = 3
) (
	input  logic             clk,
	input  logic             rst,
	input  ooo_pkg::issue_t  issue_i,
	output ooo_pkg::cdb_t    alu_o,
	output ooo_pkg::cdb_t    shift_o,
	output ooo_pkg::cdb_t    mult_o
);
	import ooo_pkg::*;

	localparam int N_UNITS = 3;

	logic [DATA_W-1:0] alu_res;
	logic [DATA_W-1:0] shift_res;
	logic [DATA_W-1:0] mult_res;

	logic [N_UNITS-1:0]             lane_vld;
	logic [N_UNITS-1:0][DATA_W-1:0] lane_res;
	cdb_t                           lane_out [N_UNITS];

	// Results are formed on entry and then just delayed
	always_comb begin
		case (issue_i.op)
			OP_SUB:  alu_res = issue_i.a - issue_i.b;
			OP_AND:  alu_res = issue_i.a & issue_i.b;
			OP_XOR:  alu_res = issue_i.a ^ issue_i.b;
			default: alu_res = issue_i.a + issue_i.b;
		endcase
	end

	assign shift_res = (issue_i.op == OP_SRL) ? (issue_i.a >> issue_i.b[4:0]) :
		(issue_i.a << issue_i.b[4:0]);

	// Low half of the product
	assign mult_res = issue_i.a * issue_i.b;

	assign lane_vld[0] = issue_i.valid && (issue_i.fu == FU_ALU);
	assign lane_vld[1] = issue_i.valid && (issue_i.fu == FU_SHIFT);
	assign lane_vld[2] = issue_i.valid && (issue_i.fu == FU_MULT);
	assign lane_res    = {mult_res, shift_res, alu_res};

	// ******************************
	// Per-unit delay lines
	// ******************************
	for (genvar u = 0; u < N_UNITS; u++) begin : g_unit
		localparam int LAT = (u == 0) ? ALU_LAT : (u == 1) ? SHIFT_LAT : MULT_LAT;

		logic [EX_CYCLES_MAX-1:0] vld_q;
		logic [TAG_W-1:0]         tag_q [EX_CYCLES_MAX];
		logic [DATA_W-1:0]        val_q [EX_CYCLES_MAX];

		always_ff @(posedge clk) begin
			if (rst) begin
				vld_q <= '0;
			end else begin
				vld_q <= {vld_q[EX_CYCLES_MAX-2:0], lane_vld[u]};
			end
		end

		always_ff @(posedge clk) begin
			tag_q[0] <= issue_i.dest;
			val_q[0] <= lane_res[u];
			for (int s = 1; s < EX_CYCLES_MAX; s++) begin
				tag_q[s] <= tag_q[s-1];
				val_q[s] <= val_q[s-1];
			end
		end

		// Tap at the unit's own latency
		assign lane_out[u] = '{valid: vld_q[LAT-1], tag: tag_q[LAT-1], value: val_q[LAT-1]};
	end

	assign alu_o   = lane_out[0];
	assign shift_o = lane_out[1];
	assign mult_o  = lane_out[2];

endmodule

//--- rs.sv
// ******************************
// Reservation station array
// Dispatch, issue select, completion schedule
// ******************************

`timescale 1ns/1ps

module rs #(
	parameter int RS_ENTRIES = 8,
	parameter int ALU_LAT    = 1,
	parameter int SHIFT_LAT  = 2,
	parameter int MULT_LAT   = 3
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             dispatch_vld_i,
	input  ooo_pkg::uop_t    uop_i,
	input  ooo_pkg::cdb_t    cdb_i,
	output logic             full_o,
	output ooo_pkg::issue_t  issue_o
);
	import ooo_pkg::*;

	localparam int IDX_W = $clog2(RS_ENTRIES);

	logic [RS_ENTRIES-1:0] busy_vec;
	logic [RS_ENTRIES-1:0] free_vec;
	logic [RS_ENTRIES-1:0] load_vec;
	logic [RS_ENTRIES-1:0] ready_vec;
	logic [RS_ENTRIES-1:0] allow_vec;
	logic [RS_ENTRIES-1:0] iss_req;
	logic [RS_ENTRIES-1:0] iss_vec;
	uop_t                  ent_uop [RS_ENTRIES];

	logic [RS_ENTRIES-1:0][EX_CYCLES_MAX-1:0] slot_vec;
	logic [EX_CYCLES_MAX-1:0] sched_q;
	logic [EX_CYCLES_MAX-1:0] sched_nxt;

	logic [IDX_W-1:0] iss_idx;
	logic             iss_any;
	uop_t             sel_uop;
	issue_t           iss_q;

	// Bit L-1 marks a completion L cycles after selection
	function automatic logic [EX_CYCLES_MAX-1:0] slot_of(input fu_e fu);
		int lat;
		case (fu)
			FU_SHIFT: lat = SHIFT_LAT;
			FU_MULT:  lat = MULT_LAT;
			default:  lat = ALU_LAT;
		endcase
		return EX_CYCLES_MAX'(1) << (lat - 1);
	endfunction

	// ******************************
	// Entries
	// ******************************
	for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_ent
		rs_entry u_ent (
			.clk     (clk),
			.rst     (rst),
			.load_i  (load_vec[i]),
			.uop_i   (uop_i),
			.cdb_i   (cdb_i),
			.issue_i (iss_vec[i]),
			.busy_o  (busy_vec[i]),
			.ready_o (ready_vec[i]),
			.uop_o   (ent_uop[i])
		);

		assign slot_vec[i]  = slot_of(ent_uop[i].fu);
		assign allow_vec[i] = ~|(slot_vec[i] & sched_q);
	end

	// ******************************
	// Dispatch and issue select
	// ******************************
	assign free_vec = ~busy_vec;
	assign full_o   = ~|free_vec;

	prio_select #(.WIDTH(RS_ENTRIES)) u_dp_sel (
		.req_i (free_vec),
		.en_i  (dispatch_vld_i),
		.gnt_o (load_vec),
		.idx_o (),
		.any_o ()
	);

	assign iss_req = ready_vec & allow_vec;

	prio_select #(.WIDTH(RS_ENTRIES)) u_iss_sel (
		.req_i (iss_req),
		.en_i  (1'b1),
		.gnt_o (iss_vec),
		.idx_o (iss_idx),
		.any_o (iss_any)
	);

	assign sel_uop = ent_uop[iss_idx];

	// Claim the slot, then age the whole vector by a cycle
	assign sched_nxt = (sched_q | (iss_any ? slot_vec[iss_idx] : '0)) >> 1;

	always_ff @(posedge clk) begin
		if (rst) begin
			sched_q <= '0;
			iss_q   <= '0;
		end else begin
			sched_q <= sched_nxt;
			iss_q   <= '{valid: iss_any, fu: sel_uop.fu, op: sel_uop.op, dest: sel_uop.dest,
				a: sel_uop.src_a.value, b: sel_uop.src_b.value};
		end
	end

	assign issue_o = iss_q;

endmodule

//--- rs_entry.sv
// ******************************
// Single reservation station entry
// CDB wakeup and operand capture
// ******************************

`timescale 1ns/1ps

module rs_entry (
	input  logic           clk,
	input  logic           rst,
	input  logic           load_i,
	input  ooo_pkg::uop_t  uop_i,
	input  ooo_pkg::cdb_t  cdb_i,
	input  logic           issue_i,
	output logic           busy_o,
	output logic           ready_o,
	output ooo_pkg::uop_t  uop_o
);
	import ooo_pkg::*;

	logic busy_q;
	uop_t uop_q;
	uop_t base;
	uop_t woken;

	// Grab the broadcast value if this source waits on its tag
	function automatic src_t wake(input src_t src, input cdb_t cdb);
		src_t res;
		res = src;
		if (cdb.valid && !src.rdy && (src.tag == cdb.tag)) begin
			res.rdy   = 1'b1;
			res.value = cdb.value;
		end
		return res;
	endfunction

	// Incoming uop on load, held one otherwise
	always_comb begin
		base        = load_i ? uop_i : uop_q;
		woken       = base;
		woken.src_a = wake(base.src_a, cdb_i);
		woken.src_b = wake(base.src_b, cdb_i);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
		end else if (load_i) begin
			busy_q <= 1'b1;
		end else if (issue_i) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i || busy_q) begin
			uop_q <= woken;
		end
	end

	assign busy_o  = busy_q;
	// A same-cycle broadcast already counts as ready
	assign ready_o = busy_q & woken.src_a.rdy & woken.src_b.rdy;
	assign uop_o   = woken;

endmodule

//--- prio_select.sv
// ******************************
// Lowest-index priority selector
// ******************************

`timescale 1ns/1ps

module prio_select #(
	parameter int WIDTH = 8
) (
	input  logic [WIDTH-1:0]         req_i,
	input  logic                     en_i,
	output logic [WIDTH-1:0]         gnt_o,
	output logic [$clog2(WIDTH)-1:0] idx_o,
	output logic                     any_o
);
	localparam int IDX_W = $clog2(WIDTH);

	// Scan from the top so the lowest request wins
	always_comb begin
		gnt_o = '0;
		idx_o = '0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				gnt_o    = '0;
				gnt_o[i] = en_i;
				idx_o    = IDX_W'(i);
			end
		end
	end

	assign any_o = en_i & (|req_i);

endmodule

//--- inst_decode.sv
// ******************************
// Instruction decode to unit class and operation
// ******************************

`timescale 1ns/1ps

module inst_decode (
	input  ooo_pkg::dispatch_t dispatch_i,
	output ooo_pkg::uop_t      uop_o
);
	import ooo_pkg::*;

	logic [3:0] op_raw;
	opcode_e    op;
	fu_e        fu;

	assign op_raw = dispatch_i.inst[31:28];

	// Unused codes fall back to add
	always_comb begin
		case (op_raw)
			OP_SUB, OP_AND, OP_XOR, OP_SLL, OP_SRL, OP_MUL: op = opcode_e'(op_raw);
			default: op = OP_ADD;
		endcase
	end

	always_comb begin
		case (op)
			OP_SLL, OP_SRL: fu = FU_SHIFT;
			OP_MUL:         fu = FU_MULT;
			default:        fu = FU_ALU;
		endcase
	end

	assign uop_o = '{fu: fu, op: op, dest: dispatch_i.dest,
		src_a: dispatch_i.src_a, src_b: dispatch_i.src_b};

endmodule

//--- ooo_pkg.sv
// ******************************
// Shared widths, opcode and unit enums
// Micro-op, issue and CDB structs
// ******************************

package ooo_pkg;

	localparam int TAG_W         = 6;
	localparam int DATA_W        = 32;
	// Longest unit latency, also the completion schedule length
	localparam int EX_CYCLES_MAX = 3;

	// Top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_XOR = 4'h3,
		OP_SLL = 4'h4,
		OP_SRL = 4'h5,
		OP_MUL = 4'h6
	} opcode_e;

	typedef enum logic [1:0] {
		FU_ALU   = 2'd0,
		FU_SHIFT = 2'd1,
		FU_MULT  = 2'd2
	} fu_e;

	// Source operand, either a value or a tag to wait on
	typedef struct packed {
		logic              rdy;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} src_t;

	typedef struct packed {
		logic [31:0]      inst;
		logic [TAG_W-1:0] dest;
		src_t             src_a;
		src_t             src_b;
	} dispatch_t;

	typedef struct packed {
		fu_e              fu;
		opcode_e          op;
		logic [TAG_W-1:0] dest;
		src_t             src_a;
		src_t             src_b;
	} uop_t;

	typedef struct packed {
		logic              valid;
		fu_e               fu;
		opcode_e           op;
		logic [TAG_W-1:0]  dest;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} issue_t;

	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} cdb_t;

endpackage
